/* cpu_core.f */
+incdir+rtl
rtl/cpu_data_pkg.sv
rtl/cpu_isa_pkg.sv
rtl/cpu_decode.sv
rtl/cpu_execute.sv
rtl/cpu_bus_unit.sv
rtl/cpu_core.sv
dv/cpu_core_chk.sv
dv/cpu_core_tb.sv

/* dv/cpu_core_chk.sv */
/*
  Protocol checks on the control outputs of the CPU core.
  Bound into every cpu_core instance.
*/
`timescale 1ns/1ns

module cpu_core_chk (
  input logic                clk,
  input logic                rst,
  input logic                rdy_in,
  input logic                r_nw,
  input logic                brk,
  input cpu_data_pkg::addr_t a,
  input cpu_data_pkg::byte_t dout
);

  // brk is a single clk pulse
  brk_pulse: assert property (@(posedge clk) disable iff (rst) $rose(brk) |=> !brk)
    else $error("brk stayed high for more than one clk");

  // first cycle out of reset is a read
  rnw_after_reset: assert property (@(posedge clk) $fell(rst) |-> r_nw)
    else $error("r_nw low in the clk after reset");

  // a stalled core keeps its bus outputs
  bus_hold: assert property (@(posedge clk) disable iff (rst)
                             !rdy_in |=> ($stable(a) && $stable(dout)))
    else $error("address or data output moved while ready was low");

endmodule

bind cpu_core cpu_core_chk u_chk (
  .clk(clk),
  .rst(rst),
  .rdy_in(ready),
  .r_nw(r_nw),
  .brk(brk),
  .a(a),
  .dout(dout)
);

/* dv/cpu_core_tb.sv */
/*
  Testbench for the CPU core. Runs short programs from 8000 hex on a
  combinational memory model, predicts writes and registers with an
  ISA level reference and checks them through the debug port at brk.
*/
`timescale 1ns/1ns
`include "cpu_core_macros.svh"

module cpu_core_tb;
  import cpu_isa_pkg::*;
  import cpu_data_pkg::*;

  logic     clk;
  logic     rst;
  logic     ready;
  byte_t    din;
  dbg_sel_t dbgreg_sel;
  addr_t    a;
  byte_t    dout;
  logic     r_nw;
  logic     brk;
  byte_t    dbgreg_out;

  byte_t mem [0:65535];
  byte_t ref_mem [0:65535];  // reference copy
  byte_t prog [$];
  addr_t exp_addr [$];
  byte_t exp_data [$];

  byte_t m_ac, m_x, m_y, m_s;
  logic  m_n, m_z;
  addr_t m_pc;

  integer seed = 32'h1384;
  int     write_errs;
  int     reg_errs;
  int     other_errs;
  int     writes_seen;
  int     cycles;
  int     limit;
  bit     stall_on;

  opcode_e op_table [22] = '{op_ora_zp, op_ora_imm, op_and_zp, op_and_imm, op_eor_zp,
                             op_eor_imm, op_sty_zp, op_sta_zp, op_stx_zp, op_txa, op_tya,
                             op_txs, op_ldy_imm, op_ldx_imm, op_ldy_zp, op_lda_zp,
                             op_ldx_zp, op_tay, op_lda_imm, op_tax, op_tsx, op_nop};
  opcode_e logic_ops [6] = '{op_and_imm, op_and_zp, op_eor_imm, op_eor_zp,
                             op_ora_imm, op_ora_zp};
  opcode_e xfer_ops [7]  = '{op_tax, op_tay, op_tsx, op_txa, op_txs, op_tya, op_nop};

  cpu_core u_dut (.*);

  assign din = mem[a];  // combinational read

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // run limit
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > limit)
    begin
      $display("Timeout: no brk after %0d clk cycles", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_write(input addr_t exp_a, input byte_t exp_d,
                             input addr_t got_a, input byte_t got_d);
    if ((got_a !== exp_a) || (got_d !== exp_d))
    begin
      $display("Mismatch at %0t: write %h to %h, expected %h to %h",
               $time, got_d, got_a, exp_d, exp_a);
      write_errs++;
    end
  endtask

  task automatic check_reg(input byte_t exp, input byte_t got, input int sel);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: debug select %0d reads %h, expected %h",
               $time, sel, got, exp);
      reg_errs++;
    end
  endtask

  // write strobe, sampled before the edge updates the core
  always @(posedge clk)
  begin
    if (!rst && u_dut.ph1_en && !r_nw)
    begin
      writes_seen = writes_seen + 1;
      mem[a] = dout;
      if (exp_addr.size() == 0)
      begin
        $display("Unexpected write of %h to %h at %0t", dout, a, $time);
        other_errs++;
      end
      else
        check_write(exp_addr.pop_front(), exp_data.pop_front(), a, dout);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model

  function automatic int op_len(input opcode_e op);
    case (op)
      op_brk, op_nop, op_tax, op_tay, op_tsx, op_txa, op_txs, op_tya:
        return 1;
      default:
        return 2;
    endcase
  endfunction

  // one instruction at m_pc, returns 1 on brk
  function automatic bit ref_step();
    opcode_e op;
    byte_t   opnd;
    byte_t   v;
    byte_t   res;
    bit      nz;
    op   = opcode_e'(ref_mem[m_pc]);
    opnd = ref_mem[m_pc + 16'd1];
    v    = opnd;
    res  = 8'h00;
    nz   = 1'b1;
    if (op == op_brk)
      return 1'b1;
    if ((op == op_lda_zp) || (op == op_ldx_zp) || (op == op_ldy_zp) ||
        (op == op_and_zp) || (op == op_eor_zp) || (op == op_ora_zp))
      v = ref_mem[{8'h00, opnd}];
    case (op)
      op_lda_imm, op_lda_zp: m_ac = v;
      op_ldx_imm, op_ldx_zp: m_x = v;
      op_ldy_imm, op_ldy_zp: m_y = v;
      op_and_imm, op_and_zp: m_ac = m_ac & v;
      op_eor_imm, op_eor_zp: m_ac = m_ac ^ v;
      op_ora_imm, op_ora_zp: m_ac = m_ac | v;
      op_tax: m_x = m_ac;
      op_tay: m_y = m_ac;
      op_tsx: m_x = m_s;
      op_txa: m_ac = m_x;
      op_tya: m_ac = m_y;
      op_txs: m_s = m_x;
      default:
      begin
      end
    endcase
    case (op)
      op_sta_zp, op_stx_zp, op_sty_zp:
      begin
        v = (op == op_sta_zp) ? m_ac : ((op == op_stx_zp) ? m_x : m_y);
        ref_mem[{8'h00, opnd}] = v;
        exp_addr.push_back({8'h00, opnd});
        exp_data.push_back(v);
        nz = 1'b0;
      end
      op_txs, op_nop: nz = 1'b0;  // flags untouched
      op_ldx_imm, op_ldx_zp, op_tax, op_tsx: res = m_x;
      op_ldy_imm, op_ldy_zp, op_tay: res = m_y;
      default: res = m_ac;
    endcase
    if (nz)
    begin
      m_n = res[7];
      m_z = (res == 8'h00);
    end
    m_pc = m_pc + addr_t'(op_len(op));
    return 1'b0;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // program building

  function automatic byte_t rnd_byte();
    return byte_t'($random(seed));
  endfunction

  task automatic emit(input opcode_e op, input byte_t opnd);
    prog.push_back(op);
    if (op_len(op) == 2)
      prog.push_back(opnd);
  endtask

  task automatic build_load_store();
    emit(op_lda_imm, rnd_byte());
    emit(op_ldx_imm, rnd_byte());
    emit(op_ldy_imm, 8'h00);
    emit(op_sta_zp, 8'h10);
    emit(op_stx_zp, 8'h11);
    emit(op_sty_zp, 8'h12);
    emit(op_lda_zp, 8'h11);
    emit(op_ldx_zp, 8'h12);
    emit(op_ldy_zp, 8'h10);
    emit(op_sta_zp, rnd_byte());
    emit(op_stx_zp, rnd_byte());
    emit(op_sty_zp, rnd_byte());
    emit(op_ldx_zp, 8'hF0);  // untouched fill byte
    emit(op_stx_zp, 8'hFF);
    emit(op_brk, 8'h00);
  endtask

  task automatic build_logic();
    emit(op_lda_imm, rnd_byte());
    emit(op_and_imm, 8'h00);  // forces z
    emit(op_sta_zp, 8'h20);
    emit(op_ora_imm, 8'h80);  // forces n
    emit(op_sta_zp, 8'h21);
    emit(op_eor_imm, rnd_byte());
    emit(op_and_zp, rnd_byte());
    emit(op_ora_zp, 8'h20);
    emit(op_eor_zp, 8'h21);
    for (int i = 0; i < 8; i++)
      emit(logic_ops[$unsigned($random(seed)) % 6], rnd_byte());
    emit(op_sta_zp, 8'h22);
    emit(op_brk, 8'h00);
  endtask

  task automatic build_transfers(input int n, input opcode_e table_sel);
    emit(op_lda_imm, rnd_byte());
    emit(op_ldx_imm, rnd_byte());
    emit(op_ldy_imm, rnd_byte());
    for (int i = 0; i < n; i++)
    begin
      if (table_sel == op_nop)
        emit(xfer_ops[$unsigned($random(seed)) % 7], 8'h00);
      else
        emit(op_table[$unsigned($random(seed)) % 22], rnd_byte());
    end
    emit(op_brk, 8'h00);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run control

  // brk may already be high on entry, right out of reset
  task automatic wait_brk();
    integer r;
    bit     seen;
    seen = 1'b0;
    while (!seen)
    begin
      if (brk)
      begin
        ready = 1'b0;  // freeze for the debug reads
        seen  = 1'b1;
      end
      else
      begin
        if (stall_on)
        begin
          r     = $random(seed);
          ready = (r[3:0] != 4'd0);
        end
        @(negedge clk);
      end
    end
  endtask

  task automatic check_all(input addr_t pc, input byte_t ac, input byte_t x,
                           input byte_t y, input byte_t p, input byte_t s);
    byte_t exp;
    for (int sel = 0; sel < 16; sel++)
    begin
      case (dbg_sel_t'(sel))
        `CPU_DBG_PCL: exp = pc[7:0];
        `CPU_DBG_PCH: exp = pc[15:8];
        `CPU_DBG_AC:  exp = ac;
        `CPU_DBG_X:   exp = x;
        `CPU_DBG_Y:   exp = y;
        `CPU_DBG_P:   exp = p;
        `CPU_DBG_S:   exp = s;
        default:      exp = `CPU_DBG_DEFAULT;
      endcase
      dbgreg_sel = dbg_sel_t'(sel);
      @(posedge clk);
      check_reg(exp, dbgreg_out, sel);
      @(negedge clk);
    end
  endtask

  task automatic run_program(input bit stalls);
    int    steps;
    bit    done;
    addr_t brk_pc;
    for (int i = 0; i < 65536; i++)
      mem[i] = byte_t'(i[7:0] ^ {i[11:8], i[15:12]} ^ 8'h3C);
    foreach (prog[i])
      mem[`CPU_RESET_PC + i] = prog[i];
    for (int i = 0; i < 65536; i++)
      ref_mem[i] = mem[i];
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    m_ac  = 8'h00;
    m_x   = 8'h00;
    m_y   = 8'h00;
    m_s   = `CPU_RESET_S;
    m_n   = 1'b0;
    m_z   = 1'b0;
    m_pc  = `CPU_RESET_PC;
    steps = 0;
    done  = 1'b0;
    while (!done && (steps < 500))
    begin
      done  = ref_step();
      steps = steps + 1;
    end
    brk_pc = m_pc + 16'd1;

    @(negedge clk);
    rst        = 1'b1;
    ready      = 1'b1;
    dbgreg_sel = '0;
    repeat (2) @(negedge clk);
    rst         = 1'b0;
    writes_seen = 0;
    cycles      = 0;
    limit       = steps * 4 * 4 + 200;
    stall_on    = 1'b0;

    // brk set up by reset itself
    wait_brk();
    if (writes_seen != 0)
    begin
      $display("A write happened before the first brk at %0t", $time);
      other_errs++;
    end
    check_all(`CPU_RESET_PC, 8'h00, 8'h00, 8'h00, 8'h00, `CPU_RESET_S);
    ready = 1'b1;
    while (a == `CPU_RESET_PC)
      @(negedge clk);

    stall_on = stalls;
    wait_brk();
    check_all(brk_pc, m_ac, m_x, m_y, {m_n, 5'b00000, m_z, 1'b0}, m_s);
    if (exp_addr.size() != 0)
    begin
      $display("%0d expected writes never happened", exp_addr.size());
      other_errs++;
    end
    ready    = 1'b1;
    stall_on = 1'b0;
  endtask

  initial
  begin
    rst         = 1'b1;
    ready       = 1'b1;
    dbgreg_sel  = '0;
    write_errs  = 0;
    reg_errs    = 0;
    other_errs  = 0;
    writes_seen = 0;
    cycles      = 0;
    limit       = 1000;
    stall_on    = 1'b0;

    build_load_store();
    run_program(1'b0);
    build_logic();
    run_program(1'b0);
    // txs keeps the flags of the lda
    emit(op_ldx_imm, 8'h80);
    emit(op_lda_imm, 8'h00);
    emit(op_txs, 8'h00);
    emit(op_brk, 8'h00);
    run_program(1'b0);
    build_transfers(20, op_nop);
    run_program(1'b0);
    for (int i = 0; i < 4; i++)
    begin
      build_transfers(30, op_brk);  // mixed instructions under stalls
      run_program(1'b1);
    end
    build_load_store();
    run_program(1'b1);

    $display("Errors: write %0d, register %0d, other %0d", write_errs, reg_errs, other_errs);
    if ((write_errs + reg_errs + other_errs) == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

/* rtl/cpu_bus_unit.sv */
/*
  Bus side of the core: program counter, address bus registers, the
  input data latch with its predecode copy and the data output register.
*/
`timescale 1ns/1ns
`include "cpu_core_macros.svh"

module cpu_bus_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                ph1_en,
  input  logic                ph2_en,
  input  logic                load_prg_byte,
  input  logic                zp_addr_to_ab,
  input  cpu_data_pkg::byte_t din,
  input  cpu_data_pkg::byte_t db_out,
  output cpu_data_pkg::addr_t a,
  output cpu_data_pkg::byte_t dout,
  output cpu_data_pkg::byte_t dl,
  output cpu_data_pkg::byte_t pd,
  output cpu_data_pkg::byte_t pcl,
  output cpu_data_pkg::byte_t pch
);
  import cpu_data_pkg::*;

  addr_t q_pc;
  byte_t q_abh;
  byte_t q_abl;
  byte_t q_dor;
  byte_t adl;     // ADL bus
  byte_t adh;     // ADH bus
  logic  ab_load;

  assign pcl = q_pc[7:0];
  assign pch = q_pc[15:8];

  // zero page wins over pc on ADL, ADH stays 0 for zero page
  assign adl     = zp_addr_to_ab ? dl : (load_prg_byte ? pcl : 8'h00);
  assign adh     = load_prg_byte ? pch : 8'h00;
  assign ab_load = load_prg_byte | zp_addr_to_ab;

  // phase 1 registers
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      q_abh <= byte_t'(`CPU_RESET_PC >> 8);
      q_abl <= byte_t'(`CPU_RESET_PC);
      q_dor <= 8'h00;
    end
    else if (ph1_en)
    begin
      if (ab_load)
      begin
        q_abh <= adh;
        q_abl <= adl;
      end
      q_dor <= db_out;
    end
  end

  // phase 2 registers
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      q_pc <= `CPU_RESET_PC;
      dl   <= 8'h00;
      pd   <= 8'h00;
    end
    else if (ph2_en)
    begin
      if (load_prg_byte)
        q_pc <= q_pc + 16'h0001;
      dl <= din;
      pd <= din;  // opcode prefetch
    end
  end

  assign a    = {q_abh, q_abl};
  assign dout = q_dor;

endmodule

/* rtl/cpu_core.sv */
/*
  Top level of the CPU core. Connects decode, execute and bus stages
  and provides read access to the registers by debug select code.
*/
`timescale 1ns/1ns
`include "cpu_core_macros.svh"

module cpu_core (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ready,
  input  cpu_data_pkg::byte_t    din,
  input  cpu_data_pkg::dbg_sel_t dbgreg_sel,
  output cpu_data_pkg::addr_t    a,
  output cpu_data_pkg::byte_t    dout,
  output logic                   r_nw,
  output logic                   brk,
  output cpu_data_pkg::byte_t    dbgreg_out
);
  import cpu_data_pkg::*;

  logic  ph1_en, ph2_en;
  logic  load_prg_byte, zp_addr_to_ab, dl_and_ac_to_alu;
  logic  lda_last, ldx_last, ldy_last;
  logic  and_last, eor_last, ora_last;
  logic  ac_to_dor, x_to_dor, y_to_dor;
  logic  tax, tay, tsx, txa, txs, tya;
  byte_t db_out;
  byte_t dl;
  byte_t pd;
  byte_t pcl, pch;
  byte_t ac, x, y, s, p;  // debug view

  // stage ports share names with the nets above
  cpu_decode u_decode (
    .rdy_in(ready),
    .*
  );

  cpu_execute u_execute (.*);

  cpu_bus_unit u_bus (.*);

  always_comb
  begin
    case (dbgreg_sel)
      `CPU_DBG_PCL: dbgreg_out = pcl;
      `CPU_DBG_PCH: dbgreg_out = pch;
      `CPU_DBG_AC:  dbgreg_out = ac;
      `CPU_DBG_X:   dbgreg_out = x;
      `CPU_DBG_Y:   dbgreg_out = y;
      `CPU_DBG_P:   dbgreg_out = p;
      `CPU_DBG_S:   dbgreg_out = s;
      default:      dbgreg_out = `CPU_DBG_DEFAULT;
    endcase
  end

endmodule

/* rtl/cpu_core_macros.svh */
/*
  Constants shared by the CPU core and its testbench.
  Reset values for the program counter and stack pointer, plus the
  debug register select codes. Include wherever these are needed.
*/
`ifndef CPU_CORE_MACROS_SVH
`define CPU_CORE_MACROS_SVH

// reset state
`define CPU_RESET_PC 16'h8000
`define CPU_RESET_S  8'hFF

// debug register select codes
`define CPU_DBG_PCL 4'd0
`define CPU_DBG_PCH 4'd1
`define CPU_DBG_AC  4'd2
`define CPU_DBG_X   4'd3
`define CPU_DBG_Y   4'd4
`define CPU_DBG_P   4'd5
`define CPU_DBG_S   4'd6

// read back for any select code without a register behind it
`define CPU_DBG_DEFAULT 8'hBD

`endif

/* rtl/cpu_data_pkg.sv */
/*
  Datapath types of the core: data bytes, bus addresses, the clock
  phase within a machine cycle and the debug register select.
*/
package cpu_data_pkg;

  // one data byte on any internal bus or register
  typedef logic [7:0] byte_t;

  // external address bus
  typedef logic [15:0] addr_t;

  // four phases per machine cycle, 0 is phase 1 update, 2 is phase 2
  typedef logic [1:0] phase_t;

  // debug register select
  typedef logic [3:0] dbg_sel_t;

endpackage

/* rtl/cpu_decode.sv */
/*
  Control stage of the core. Generates the four-phase machine cycle
  with the ready stall, steps the T-state timing generator, holds the
  instruction register and decodes state and opcode into strobes.
*/
`timescale 1ns/1ns

module cpu_decode (
  input  logic                clk,
  input  logic                rst,
  input  logic                rdy_in,
  input  cpu_data_pkg::byte_t pd,
  output logic                ph1_en,
  output logic                ph2_en,
  output logic                load_prg_byte,   // pc to address bus, increment pc
  output logic                lda_last,
  output logic                ldx_last,
  output logic                ldy_last,
  output logic                and_last,
  output logic                eor_last,
  output logic                ora_last,
  output logic                ac_to_dor,
  output logic                x_to_dor,
  output logic                y_to_dor,
  output logic                zp_addr_to_ab,   // zero page address from dl
  output logic                dl_and_ac_to_alu,
  output logic                tax,
  output logic                tay,
  output logic                tsx,
  output logic                txa,
  output logic                txs,
  output logic                tya,
  output logic                r_nw,
  output logic                brk
);
  import cpu_isa_pkg::*;
  import cpu_data_pkg::*;

  logic    q_ready;  // ready delayed one clk
  logic    rdy;      // internal ready
  phase_t  q_phase;
  tstate_e q_t;
  tstate_e d_t;
  opcode_e q_ir;

  ////////////////////////////////////////////////////////////////////////////
  // machine cycle phases

  // the extra clk of ready delay lets the outside address mux settle
  always_ff @(posedge clk)
  begin
    if (rst)
      q_ready <= 1'b1;
    else
      q_ready <= rdy_in;
  end

  assign rdy = rdy_in && q_ready;

  always_ff @(posedge clk)
  begin
    if (rst)
      q_phase <= 2'd1;
    else if (rdy)
      q_phase <= q_phase + 2'd1;
  end

  assign ph1_en = rdy && (q_phase == 2'd0);
  assign ph2_en = rdy && (q_phase == 2'd2);

  ////////////////////////////////////////////////////////////////////////////
  // timing generator and instruction register

  always_comb
  begin
    case (q_t)
      ts_t0:
        d_t = ts_t1;
      ts_t1:
        case (q_ir)
          op_brk, op_nop, op_tax, op_tay, op_tsx, op_txa, op_txs, op_tya:
            d_t = ts_t1;  // next opcode already prefetched
          op_lda_imm, op_ldx_imm, op_ldy_imm:
            d_t = ts_t0;
          default:
            d_t = ts_t2;
        endcase
      ts_t2:
        case (q_ir)
          op_and_imm, op_eor_imm, op_ora_imm:
            d_t = ts_t1;
          op_lda_zp, op_ldx_zp, op_ldy_zp, op_sta_zp, op_stx_zp, op_sty_zp:
            d_t = ts_t0;  // bus busy, no prefetch
          default:
            d_t = ts_t3;
        endcase
      ts_t3:
        if ((q_ir == op_and_zp) || (q_ir == op_eor_zp) || (q_ir == op_ora_zp))
          d_t = ts_t1;
        else
          d_t = ts_t4;
      default:
        d_t = ts_t0;  // unknown opcodes run out here
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      q_t  <= ts_t1;
      q_ir <= op_brk;
    end
    else if (ph1_en)
    begin
      q_t <= d_t;
      if (d_t == ts_t1)
        q_ir <= opcode_e'(pd);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // decode rom

  always_comb
  begin
    load_prg_byte    = 1'b0;
    lda_last         = 1'b0;
    ldx_last         = 1'b0;
    ldy_last         = 1'b0;
    and_last         = 1'b0;
    eor_last         = 1'b0;
    ora_last         = 1'b0;
    ac_to_dor        = 1'b0;
    x_to_dor         = 1'b0;
    y_to_dor         = 1'b0;
    zp_addr_to_ab    = 1'b0;
    dl_and_ac_to_alu = 1'b0;
    tax              = 1'b0;
    tay              = 1'b0;
    tsx              = 1'b0;
    txa              = 1'b0;
    txs              = 1'b0;
    tya              = 1'b0;
    r_nw             = 1'b1;
    brk              = 1'b0;

    case (q_t)
      ts_t0:
        load_prg_byte = 1'b1;
      ts_t1:
        case (q_ir)
          op_and_imm, op_eor_imm, op_ora_imm:
          begin
            load_prg_byte    = 1'b1;
            dl_and_ac_to_alu = 1'b1;
          end
          op_and_zp, op_eor_zp, op_ora_zp, op_lda_zp, op_ldx_zp, op_ldy_zp:
            zp_addr_to_ab = 1'b1;
          op_sta_zp, op_stx_zp, op_sty_zp:
          begin
            zp_addr_to_ab = 1'b1;
            ac_to_dor     = (q_ir == op_sta_zp);
            x_to_dor      = (q_ir == op_stx_zp);
            y_to_dor      = (q_ir == op_sty_zp);
          end
          op_lda_imm, op_ldx_imm, op_ldy_imm:
          begin
            load_prg_byte = 1'b1;
            lda_last      = (q_ir == op_lda_imm);
            ldx_last      = (q_ir == op_ldx_imm);
            ldy_last      = (q_ir == op_ldy_imm);
          end
          op_brk:
          begin
            load_prg_byte = 1'b1;
            brk           = (q_phase == 2'd1) && rdy;  // single clk at cycle start
          end
          op_nop, op_tax, op_tay, op_tsx, op_txa, op_txs, op_tya:
          begin
            load_prg_byte = 1'b1;
            tax           = (q_ir == op_tax);
            tay           = (q_ir == op_tay);
            tsx           = (q_ir == op_tsx);
            txa           = (q_ir == op_txa);
            txs           = (q_ir == op_txs);
            tya           = (q_ir == op_tya);
          end
          default:
          begin
          end
        endcase
      ts_t2:
        case (q_ir)
          op_and_imm, op_eor_imm, op_ora_imm:
          begin
            load_prg_byte = 1'b1;
            and_last      = (q_ir == op_and_imm);
            eor_last      = (q_ir == op_eor_imm);
            ora_last      = (q_ir == op_ora_imm);
          end
          op_and_zp, op_eor_zp, op_ora_zp:
          begin
            load_prg_byte    = 1'b1;
            dl_and_ac_to_alu = 1'b1;
          end
          op_lda_zp, op_ldx_zp, op_ldy_zp:
          begin
            load_prg_byte = 1'b1;
            lda_last      = (q_ir == op_lda_zp);
            ldx_last      = (q_ir == op_ldx_zp);
            ldy_last      = (q_ir == op_ldy_zp);
          end
          op_sta_zp, op_stx_zp, op_sty_zp:
          begin
            load_prg_byte = 1'b1;
            r_nw          = 1'b0;  // dor goes out at the zp address
          end
          default:
          begin
          end
        endcase
      ts_t3:
        if ((q_ir == op_and_zp) || (q_ir == op_eor_zp) || (q_ir == op_ora_zp))
        begin
          load_prg_byte = 1'b1;
          and_last      = (q_ir == op_and_zp);
          eor_last      = (q_ir == op_eor_zp);
          ora_last      = (q_ir == op_ora_zp);
        end
      default:
      begin
      end
    endcase
  end

endmodule

/* rtl/cpu_execute.sv */
/*
  Execute stage. Turns the decode strobes into bus drives, merges the
  SB and DB buses as the pass gates would, and updates the user
  registers, the N and Z flags and the logic ALU.
*/
`timescale 1ns/1ns
`include "cpu_core_macros.svh"

module cpu_execute (
  input  logic                clk,
  input  logic                rst,
  input  logic                ph1_en,
  input  logic                ph2_en,
  input  logic                lda_last,
  input  logic                ldx_last,
  input  logic                ldy_last,
  input  logic                and_last,
  input  logic                eor_last,
  input  logic                ora_last,
  input  logic                ac_to_dor,
  input  logic                x_to_dor,
  input  logic                y_to_dor,
  input  logic                dl_and_ac_to_alu,
  input  logic                tax,
  input  logic                tay,
  input  logic                tsx,
  input  logic                txa,
  input  logic                txs,
  input  logic                tya,
  input  cpu_data_pkg::byte_t dl,
  output cpu_data_pkg::byte_t db_out,
  output cpu_data_pkg::byte_t ac,
  output cpu_data_pkg::byte_t x,
  output cpu_data_pkg::byte_t y,
  output cpu_data_pkg::byte_t s,
  output cpu_data_pkg::byte_t p
);
  import cpu_data_pkg::*;

  byte_t q_ai;    // alu input a
  byte_t q_bi;    // alu input b
  byte_t q_add;   // alu hold
  byte_t d_add;
  logic  q_n;
  logic  q_z;
  byte_t db_in;
  byte_t sb_in;
  byte_t sb_out;
  logic  ld_last;
  logic  logic_last;
  logic  ac_db, dl_db;                    // db drivers
  logic  ac_sb, add_sb, x_sb, y_sb, s_sb; // sb drivers
  logic  sb_db;                           // sb/db pass gate
  logic  set_nz;

  // bus control
  assign ld_last    = lda_last | ldx_last | ldy_last;
  assign logic_last = and_last | eor_last | ora_last;
  assign ac_db      = ac_to_dor;
  assign dl_db      = ld_last | dl_and_ac_to_alu;
  assign ac_sb      = dl_and_ac_to_alu | tax | tay;
  assign add_sb     = logic_last;
  assign x_sb       = x_to_dor | txs | txa;
  assign y_sb       = y_to_dor | tya;
  assign s_sb       = tsx;
  assign sb_db      = ld_last | logic_last | x_to_dor | y_to_dor |
                      tax | tay | tsx | txa | tya;
  assign set_nz     = ld_last | logic_last | tax | tay | tsx | txa | tya;  // not txs

  assign db_in = ac_db ? ac : (dl_db ? dl : 8'h00);
  assign sb_in = ac_sb  ? ac    :
                 add_sb ? q_add :
                 x_sb   ? x     :
                 y_sb   ? y     :
                 s_sb   ? s     : 8'h00;

  // closed pass gate shorts both buses
  assign db_out = sb_db ? (db_in | sb_in) : db_in;
  assign sb_out = sb_db ? (sb_in | db_in) : sb_in;

  always_comb
  begin
    if (and_last)
      d_add = q_ai & q_bi;
    else if (eor_last)
      d_add = q_ai ^ q_bi;
    else if (ora_last)
      d_add = q_ai | q_bi;
    else
      d_add = q_add;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ac   <= 8'h00;
      x    <= 8'h00;
      y    <= 8'h00;
      s    <= `CPU_RESET_S;
      q_n  <= 1'b0;
      q_z  <= 1'b0;
      q_ai <= 8'h00;
      q_bi <= 8'h00;
    end
    else if (ph1_en)
    begin
      if (lda_last | txa | tya | logic_last)
        ac <= sb_out;
      if (ldx_last | tax | tsx)
        x <= sb_out;
      if (ldy_last | tay)
        y <= sb_out;
      if (txs)
        s <= sb_out;
      if (set_nz)
      begin
        q_n <= db_out[7];
        q_z <= ~|db_out;
      end
      if (dl_and_ac_to_alu)
      begin
        q_ai <= sb_out;  // ac
        q_bi <= db_out;  // dl
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      q_add <= 8'h00;
    else if (ph2_en)
      q_add <= d_add;
  end

  assign p = {q_n, 5'b00000, q_z, 1'b0};

endmodule

/* rtl/cpu_isa_pkg.sv */
/*
  Instruction set view of the core: opcode encodings of the supported
  instructions and the timing generator states.
*/
package cpu_isa_pkg;

  // supported opcodes, standard 6502 encodings
  typedef enum logic [7:0] {
    op_brk     = 8'h00,
    op_ora_zp  = 8'h05,
    op_ora_imm = 8'h09,
    op_and_zp  = 8'h25,
    op_and_imm = 8'h29,
    op_eor_zp  = 8'h45,
    op_eor_imm = 8'h49,
    op_sty_zp  = 8'h84,
    op_sta_zp  = 8'h85,
    op_stx_zp  = 8'h86,
    op_txa     = 8'h8A,
    op_tya     = 8'h98,
    op_txs     = 8'h9A,
    op_ldy_imm = 8'hA0,
    op_ldx_imm = 8'hA2,
    op_ldy_zp  = 8'hA4,
    op_lda_zp  = 8'hA5,
    op_ldx_zp  = 8'hA6,
    op_tay     = 8'hA8,
    op_lda_imm = 8'hA9,
    op_tax     = 8'hAA,
    op_tsx     = 8'hBA,
    op_nop     = 8'hEA
  } opcode_e;

  // machine cycle within an instruction
  // t0 is a bare opcode fetch, t1 the first cycle after it
  typedef enum logic [2:0] {
    ts_t0 = 3'd0,
    ts_t1 = 3'd1,
    ts_t2 = 3'd2,
    ts_t3 = 3'd3,
    ts_t4 = 3'd4
  } tstate_e;

endpackage

/* run.sh */
#!/usr/bin/env bash
# Build the CPU core regression with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f cpu_core.f --top-module cpu_core_tb -o sim_cpu_core

./obj_dir/sim_cpu_core > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
